// ==== verilog.f ====
+incdir+include
hw/pitch_pkg.sv
hw/corr_buffer.sv
hw/lag_search.sv
hw/frac_interp.sv
hw/pitch_control.sv
hw/pitch_fr3_top.sv
test/pitch_fr3_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP := pitch_fr3_tb
FILELIST := verilog.f
BUILD_DIR := obj_dir
LOG := sim.log
PASS_MSG := All tests passed

VFLAGS := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/pitch_fr3_tb.sv ====
`timescale 1ns/1ps

`include "pitch_macros.svh"

module pitch_fr3_tb;

	localparam int clock_period = 100;
	localparam int run_count = 20;
	localparam int worst_run = (`PIT_MAX - `PIT_MIN + 3) + 5 * 13 + 8;
	localparam int load_cycles = 2**`CORR_AW + 2;
	localparam int watchdog_cycles = 2 * run_count * (worst_run + load_cycles) + 100;

	logic clock;
	logic reset;
	pitch_pkg::corr_wr_t corr_wr;
	logic start;
	pitch_pkg::search_req_t req;
	logic first_subfr;
	logic done;
	pitch_pkg::pitch_res_t result;

	// Model copy of the correlation buffer
	pitch_pkg::word_t corr_mem [2**`CORR_AW];

	int value_errors;
	int timeout_errors;

	pitch_fr3_top dut0 (
		.clock(clock),
		.reset(reset),
		.corr_wr(corr_wr),
		.start(start),
		.req(req),
		.first_subfr(first_subfr),
		.done(done),
		.result(result)
	);

	always #(clock_period / 2) clock = ~clock;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Doubled product into a 32-bit sum with both steps saturating
	function automatic pitch_pkg::acc_t mac_sat(input pitch_pkg::acc_t s,
		input pitch_pkg::word_t a, input pitch_pkg::word_t b);
		longint prod;
		longint sum;
		prod = 2 * longint'(a) * longint'(b);
		if (prod > 64'sd2147483647) begin
			prod = 64'sd2147483647;
		end
		sum = longint'(s) + prod;
		if (sum > 64'sd2147483647) begin
			sum = 64'sd2147483647;
		end else if (sum < -64'sd2147483648) begin
			sum = -64'sd2147483648;
		end
		return pitch_pkg::acc_t'(sum);
	endfunction

	function automatic pitch_pkg::word_t interp_at(input pitch_pkg::lag_t lag,
		input pitch_pkg::frac_t frac);
		int base;
		int f;
		pitch_pkg::acc_t s;
		longint r;
		base = int'(lag);
		f = int'(frac);
		if (f < 0) begin
			f = f + `UP_SAMP;
			base = base - 1;
		end
		s = '0;
		for (int k = 0; k < `L_INTER4; k++) begin
			s = mac_sat(s, corr_mem[base - k],
				pitch_pkg::inter_3[f + `UP_SAMP * k]);
			s = mac_sat(s, corr_mem[base + 1 + k],
				pitch_pkg::inter_3[`UP_SAMP - f + `UP_SAMP * k]);
		end
		r = longint'(s) + 64'sd32768;
		if (r > 64'sd2147483647) begin
			return 16'sh7fff;
		end
		return pitch_pkg::word_t'(r >>> 16);
	endfunction

	function automatic void pitch_model(input pitch_pkg::search_req_t r, input logic first,
		output pitch_pkg::search_res_t srch, output pitch_pkg::pitch_res_t res);
		pitch_pkg::word_t val;
		pitch_pkg::word_t best_val;
		pitch_pkg::frac_t best_frac;
		srch.lag = r.t_min;
		srch.corr = 16'sh8000;
		// Later lag wins a tie
		for (int l = r.t_min; l <= r.t_max; l++) begin
			if (corr_mem[l] >= srch.corr) begin
				srch.corr = corr_mem[l];
				srch.lag = pitch_pkg::lag_t'(l);
			end
		end
		res.lag = srch.lag;
		res.frac = '0;
		if (!(first && srch.lag > `EARLY_LAG)) begin
			best_val = '0;
			best_frac = -3'sd2;
			for (int fr = -2; fr <= 2; fr++) begin
				val = interp_at(srch.lag, pitch_pkg::frac_t'(fr));
				if (fr == -2 || val > best_val) begin
					best_val = val;
					best_frac = pitch_pkg::frac_t'(fr);
				end
			end
			if (best_frac == -3'sd2) begin
				res.lag = srch.lag - 1'b1;
				res.frac = 3'sd1;
			end else if (best_frac == 3'sd2) begin
				res.lag = srch.lag + 1'b1;
				res.frac = -3'sd1;
			end else begin
				res.frac = best_frac;
			end
		end
	endfunction

	function automatic pitch_pkg::pitch_res_t expect_res(input int lag, input int frac);
		pitch_pkg::pitch_res_t res;
		res.lag = pitch_pkg::lag_t'(lag);
		res.frac = pitch_pkg::frac_t'(frac);
		return res;
	endfunction

	// Far below any peak and varying a little with the lag
	function automatic pitch_pkg::word_t background(input int a);
		return pitch_pkg::word_t'(-16000 - ((a * 53) % 101));
	endfunction

	function automatic void fill_background();
		for (int a = 0; a < 2**`CORR_AW; a++) begin
			corr_mem[a] = background(a);
		end
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_result(input pitch_pkg::pitch_res_t got,
		input pitch_pkg::pitch_res_t exp, input string what);
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0d ns: %s: lag %0d frac %0d, expected lag %0d frac %0d",
				$time, what, got.lag, got.frac, exp.lag, exp.frac);
		end
	endtask

	task automatic check_word(input pitch_pkg::word_t got, input pitch_pkg::word_t exp,
		input string what);
		if (got !== exp) begin
			value_errors++;
			$display("** Error at %0d ns: %s: got %0d, expected %0d",
				$time, what, got, exp);
		end
	endtask

	//////////////////////////////
	// Drivers
	//////////////////////////////

	task automatic load_corr();
		for (int a = 0; a < 2**`CORR_AW; a++) begin
			@(posedge clock);
			#1;
			corr_wr.en = 1'b1;
			corr_wr.addr = pitch_pkg::lag_t'(a);
			corr_wr.data = corr_mem[a];
		end
		@(posedge clock);
		#1;
		corr_wr.en = 1'b0;
	endtask

	task automatic run_pitch(input pitch_pkg::search_req_t r, input logic first);
		int waited;
		@(posedge clock);
		#1;
		req = r;
		first_subfr = first;
		start = 1'b1;
		@(posedge clock);
		#1;
		start = 1'b0;
		waited = 0;
		while (!done && waited < 2 * worst_run) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (!done) begin
			timeout_errors++;
			$display("Timeout: done did not arrive within %0d cycles of start", 2 * worst_run);
		end
	endtask

	task automatic check_run(input pitch_pkg::search_req_t r, input logic first,
		input string what);
		pitch_pkg::search_res_t srch;
		pitch_pkg::pitch_res_t exp;
		pitch_model(r, first, srch, exp);
		run_pitch(r, first);
		check_result(result, exp, what);
		check_word(dut0.search_res.corr, srch.corr, $sformatf("%s peak value", what));
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic test_reset();
		@(posedge clock);
		#1;
		reset = 1'b1;
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;
		if (done !== 1'b0) begin
			value_errors++;
			$display("** Error at %0d ns: done is not low after reset", $time);
		end
		check_result(result, expect_res(0, 0), "result after reset");
	endtask

	task automatic test_single_peak();
		pitch_pkg::search_req_t r;
		fill_background();
		for (int d = -8; d <= 8; d++) begin
			corr_mem[60 + d] = pitch_pkg::word_t'(14000 - 150 * d * d);
		end
		load_corr();
		r.t_min = 8'd30;
		r.t_max = 8'd100;
		check_run(r, 1'b0, "single peak");
	endtask

	task automatic test_equal_peaks();
		pitch_pkg::search_req_t r;
		r.t_min = 8'(`PIT_MIN);
		r.t_max = 8'(`PIT_MAX);
		fill_background();
		corr_mem[100] = 16'sd15000;
		corr_mem[120] = 16'sd15000;
		load_corr();
		check_run(r, 1'b1, "equal peaks, first subframe");
		check_result(result, expect_res(120, 0), "later of two long lags");
		fill_background();
		corr_mem[40] = 16'sd15000;
		corr_mem[70] = 16'sd15000;
		load_corr();
		check_run(r, 1'b0, "equal peaks");
		check_result(result, expect_res(70, 0), "later of two short lags");
	endtask

	// One-sided slope so that a refined run leaves the integer lag
	task automatic test_early_exit();
		pitch_pkg::search_req_t r;
		fill_background();
		for (int l = 110; l <= 120; l++) begin
			corr_mem[l] = pitch_pkg::word_t'(8000 - 10 * (l - 110));
		end
		load_corr();
		r.t_min = 8'd60;
		r.t_max = 8'd140;
		check_run(r, 1'b1, "early exit");
		check_result(result, expect_res(110, 0), "early exit integer lag");
		check_run(r, 1'b0, "same data, later subframe");
		check_result(result, expect_res(111, -1), "later subframe refined");
	endtask

	// Plateau on one side of the peak pulls the best point to the edge fraction
	task automatic test_edge_fractions();
		pitch_pkg::search_req_t r;
		r.t_min = 8'd30;
		r.t_max = 8'd130;
		fill_background();
		for (int l = 80; l <= 90; l++) begin
			corr_mem[l] = pitch_pkg::word_t'(8000 - 10 * (l - 80));
		end
		load_corr();
		check_run(r, 1'b0, "fraction +2 edge");
		check_result(result, expect_res(81, -1), "fraction +2 folded");
		fill_background();
		for (int l = 70; l <= 80; l++) begin
			corr_mem[l] = pitch_pkg::word_t'(8000 - 10 * (80 - l));
		end
		load_corr();
		check_run(r, 1'b0, "fraction -2 edge");
		check_result(result, expect_res(79, 1), "fraction -2 folded");
	endtask

	task automatic test_random();
		pitch_pkg::search_req_t r;
		logic first;
		for (int n = 0; n < 10; n++) begin
			for (int a = 0; a < 2**`CORR_AW; a++) begin
				corr_mem[a] = pitch_pkg::word_t'($urandom);
			end
			load_corr();
			r.t_min = pitch_pkg::lag_t'(`PIT_MIN + $urandom % (`PIT_MAX - `PIT_MIN + 1));
			r.t_max = pitch_pkg::lag_t'(r.t_min + $urandom % (`PIT_MAX - r.t_min + 1));
			first = 1'($urandom % 2);
			check_run(r, first, $sformatf("random table %0d", n));
		end
	endtask

	//////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////

	initial begin
		void'($urandom(58));
		value_errors = 0;
		timeout_errors = 0;
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		req = '0;
		first_subfr = 1'b0;
		corr_wr = '0;
		test_reset();
		test_single_peak();
		test_equal_peaks();
		test_early_exit();
		test_edge_fractions();
		test_random();
		// Reset again with a nonzero result held
		test_reset();
		$display("Errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#(longint'(watchdog_cycles) * clock_period);
		$display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
		$display("Some tests failed");
		$finish;
	end

endmodule

// ==== hw/pitch_fr3_top.sv ====
`timescale 1ns/1ps

module pitch_fr3_top (
	input logic clock,
	input logic reset,
	input pitch_pkg::corr_wr_t corr_wr,
	input logic start,
	input pitch_pkg::search_req_t req,
	input logic first_subfr,
	output logic done,
	output pitch_pkg::pitch_res_t result
);

	pitch_pkg::lag_t rd_addr_a;
	pitch_pkg::word_t rd_data_a;
	pitch_pkg::lag_t rd_addr_b;
	pitch_pkg::word_t rd_data_b;

	logic search_start;
	logic search_done;
	pitch_pkg::search_res_t search_res;

	logic interp_start;
	pitch_pkg::interp_req_t interp_req;
	logic interp_done;
	pitch_pkg::word_t interp_value;

	corr_buffer buffer0 (
		.clock(clock),
		.wr(corr_wr),
		.rd_addr_a(rd_addr_a),
		.rd_data_a(rd_data_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_b(rd_data_b)
	);

	// Integer lag search on port A
	lag_search search0 (
		.clock(clock),
		.reset(reset),
		.start(search_start),
		.req(req),
		.rd_addr(rd_addr_a),
		.rd_data(rd_data_a),
		.done(search_done),
		.res(search_res)
	);

	// Fractional interpolation on port B
	frac_interp interp0 (
		.clock(clock),
		.reset(reset),
		.start(interp_start),
		.req(interp_req),
		.rd_addr(rd_addr_b),
		.rd_data(rd_data_b),
		.done(interp_done),
		.value(interp_value)
	);

	pitch_control control0 (
		.clock(clock),
		.reset(reset),
		.start(start),
		.req(req),
		.first_subfr(first_subfr),
		.search_start(search_start),
		.search_done(search_done),
		.search_res(search_res),
		.interp_start(interp_start),
		.interp_req(interp_req),
		.interp_done(interp_done),
		.interp_value(interp_value),
		.done(done),
		.result(result)
	);

endmodule

// ==== hw/pitch_control.sv ====
`timescale 1ns/1ps

`include "pitch_macros.svh"

module pitch_control (
	input logic clock,
	input logic reset,
	input logic start,
	input pitch_pkg::search_req_t req,
	input logic first_subfr,
	output logic search_start,
	input logic search_done,
	input pitch_pkg::search_res_t search_res,
	output logic interp_start,
	output pitch_pkg::interp_req_t interp_req,
	input logic interp_done,
	input pitch_pkg::word_t interp_value,
	output logic done,
	output pitch_pkg::pitch_res_t result
);

	pitch_pkg::ctrl_state_e state;

	pitch_pkg::lag_t best_lag;
	pitch_pkg::frac_t cur_frac;
	pitch_pkg::frac_t best_frac;
	pitch_pkg::word_t max_val;

	assign interp_req.lag = best_lag;
	assign interp_req.frac = cur_frac;

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= pitch_pkg::ctrl_idle;
			search_start <= 1'b0;
			interp_start <= 1'b0;
			cur_frac <= '0;
			done <= 1'b0;
			result <= '0;
		end else begin
			search_start <= 1'b0;
			interp_start <= 1'b0;
			done <= 1'b0;
			case (state)
				pitch_pkg::ctrl_idle: begin
					if (start && req.t_min <= req.t_max) begin
						search_start <= 1'b1;
						state <= pitch_pkg::ctrl_search;
					end
				end
				pitch_pkg::ctrl_search: begin
					if (search_done) begin
						state <= pitch_pkg::ctrl_check;
					end
				end
				pitch_pkg::ctrl_check: begin
					// Long lags in the first subframe keep the integer lag
					if (first_subfr && best_lag > `EARLY_LAG) begin
						state <= pitch_pkg::ctrl_finish;
					end else begin
						cur_frac <= -3'sd2;
						interp_start <= 1'b1;
						state <= pitch_pkg::ctrl_interp;
					end
				end
				pitch_pkg::ctrl_interp: begin
					if (interp_done) begin
						if (cur_frac == 3'sd2) begin
							state <= pitch_pkg::ctrl_adjust;
						end else begin
							cur_frac <= cur_frac + 3'sd1;
							interp_start <= 1'b1;
						end
					end
				end
				pitch_pkg::ctrl_adjust: begin
					state <= pitch_pkg::ctrl_finish;
				end
				pitch_pkg::ctrl_finish: begin
					result.lag <= best_lag;
					result.frac <= best_frac;
					done <= 1'b1;
					state <= pitch_pkg::ctrl_idle;
				end
				default: state <= pitch_pkg::ctrl_idle;
			endcase
		end
	end

	//////////////////////////////
	// Best lag and fraction
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (state == pitch_pkg::ctrl_search && search_done) begin
			best_lag <= search_res.lag;
			best_frac <= '0;
		end
		// Strictly larger, first candidate is -2
		if (state == pitch_pkg::ctrl_interp && interp_done) begin
			if (cur_frac == -3'sd2 || interp_value > max_val) begin
				max_val <= interp_value;
				best_frac <= cur_frac;
			end
		end
		// Edge fractions fold onto the neighbouring lag
		if (state == pitch_pkg::ctrl_adjust) begin
			if (best_frac == -3'sd2) begin
				best_frac <= 3'sd1;
				best_lag <= best_lag - 1'b1;
			end else if (best_frac == 3'sd2) begin
				best_frac <= -3'sd1;
				best_lag <= best_lag + 1'b1;
			end
		end
	end

	a_done_pulse: assert property (@(posedge clock) disable iff (reset)
		done |=> !done)
		else $error("pitch_control done held for more than one cycle");

endmodule

// ==== hw/frac_interp.sv ====
`timescale 1ns/1ps

`include "pitch_macros.svh"

module frac_interp (
	input logic clock,
	input logic reset,
	input logic start,
	input pitch_pkg::interp_req_t req,
	output pitch_pkg::lag_t rd_addr,
	input pitch_pkg::word_t rd_data,
	output logic done,
	output pitch_pkg::word_t value
);

	pitch_pkg::interp_state_e state;

	pitch_pkg::lag_t base;
	logic [1:0] frac_f;
	logic [3:0] tap;

	logic rd_valid;
	logic rd_last;
	pitch_pkg::word_t coef_q;
	pitch_pkg::acc_t acc;

	logic [1:0] tap_k;
	logic [3:0] k3;
	logic [3:0] cidx;
	logic [`ACC_W:0] rsum;

	// Doubled product added with saturation, as in L_mac
	function automatic pitch_pkg::acc_t l_mac(input pitch_pkg::acc_t s,
		input pitch_pkg::word_t a, input pitch_pkg::word_t b);
		pitch_pkg::acc_t prod;
		pitch_pkg::acc_t dbl;
		logic [`ACC_W:0] sum;
		prod = a * b;
		if (prod == 32'sh4000_0000) begin
			dbl = 32'sh7fff_ffff;
		end else begin
			dbl = prod <<< 1;
		end
		sum = {s[`ACC_W-1], s} + {dbl[`ACC_W-1], dbl};
		if (sum[`ACC_W] != sum[`ACC_W-1]) begin
			l_mac = sum[`ACC_W] ? 32'sh8000_0000 : 32'sh7fff_ffff;
		end else begin
			l_mac = sum[`ACC_W-1:0];
		end
	endfunction

	//////////////////////////////
	// Tap address and coefficient
	//////////////////////////////

	// Even taps walk down from base, odd taps walk up from base + 1
	always_comb begin
		tap_k = tap[2:1];
		k3 = 4'(tap_k) * 4'(`UP_SAMP);
		if (!tap[0]) begin
			rd_addr = base - pitch_pkg::lag_t'(tap_k);
			cidx = 4'(frac_f) + k3;
		end else begin
			rd_addr = base + pitch_pkg::lag_t'(tap_k) + 1'b1;
			cidx = 4'(`UP_SAMP) - 4'(frac_f) + k3;
		end
	end

	// Round to the upper half with saturation
	assign rsum = {acc[`ACC_W-1], acc} + ({{`ACC_W{1'b0}}, 1'b1} << (`WORD_W - 1));

	//////////////////////////////
	// Control
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= pitch_pkg::interp_idle;
			tap <= '0;
			rd_valid <= 1'b0;
			rd_last <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			rd_valid <= (state == pitch_pkg::interp_mac) && !tap[3];
			rd_last <= (tap == 4'(2 * `L_INTER4 - 1));
			case (state)
				pitch_pkg::interp_idle: begin
					tap <= '0;
					if (start) begin
						state <= pitch_pkg::interp_mac;
					end
				end
				pitch_pkg::interp_mac: begin
					if (!tap[3]) begin
						tap <= tap + 1'b1;
					end
					if (rd_valid && rd_last) begin
						state <= pitch_pkg::interp_round;
					end
				end
				pitch_pkg::interp_round: begin
					done <= 1'b1;
					state <= pitch_pkg::interp_idle;
				end
				default: state <= pitch_pkg::interp_idle;
			endcase
		end
	end

	//////////////////////////////
	// Datapath
	//////////////////////////////

	always_ff @(posedge clock) begin
		coef_q <= pitch_pkg::inter_3[cidx];
		if (state == pitch_pkg::interp_idle && start) begin
			acc <= '0;
			// Negative fraction moves to the lag below
			if (req.frac[2]) begin
				base <= req.lag - 1'b1;
				frac_f <= 2'(req.frac + 3'sd3);
			end else begin
				base <= req.lag;
				frac_f <= req.frac[1:0];
			end
		end else if (rd_valid) begin
			acc <= l_mac(acc, rd_data, coef_q);
		end
		if (state == pitch_pkg::interp_round) begin
			if (rsum[`ACC_W] != rsum[`ACC_W-1]) begin
				value <= 16'sh7fff;
			end else begin
				value <= rsum[`ACC_W-1 -: `WORD_W];
			end
		end
	end

	a_frac_range: assert property (@(posedge clock) disable iff (reset)
		start |-> ($signed(req.frac) >= -2 && $signed(req.frac) <= 2))
		else $error("frac_interp started with a fraction outside -2 to +2");

endmodule

// ==== hw/lag_search.sv ====
`timescale 1ns/1ps

`include "pitch_macros.svh"

module lag_search (
	input logic clock,
	input logic reset,
	input logic start,
	input pitch_pkg::search_req_t req,
	output pitch_pkg::lag_t rd_addr,
	input pitch_pkg::word_t rd_data,
	output logic done,
	output pitch_pkg::search_res_t res
);

	logic busy;
	pitch_pkg::lag_t addr;

	// Tracks the read that comes back from the buffer
	logic rd_valid;
	logic rd_last;
	pitch_pkg::lag_t rd_lag;

	assign rd_addr = addr;

	//////////////////////////////
	// Address stream
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			rd_valid <= 1'b0;
			rd_last <= 1'b0;
			done <= 1'b0;
		end else begin
			rd_valid <= busy;
			rd_last <= busy && (addr == req.t_max);
			done <= rd_valid && rd_last;
			if (start && !busy) begin
				busy <= 1'b1;
			end else if (busy && addr == req.t_max) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		rd_lag <= addr;
		if (start && !busy) begin
			addr <= req.t_min;
		end else if (busy) begin
			addr <= addr + 1'b1;
		end
	end

	//////////////////////////////
	// Running maximum
	//////////////////////////////

	// Greater or equal, so a later lag wins a tie
	always_ff @(posedge clock) begin
		if (start && !busy) begin
			res.corr <= {1'b1, {(`WORD_W-1){1'b0}}};
			res.lag <= req.t_min;
		end else if (rd_valid && rd_data >= res.corr) begin
			res.corr <= rd_data;
			res.lag <= rd_lag;
		end
	end

	a_lag_in_range: assert property (@(posedge clock) disable iff (reset)
		done |-> (res.lag >= req.t_min && res.lag <= req.t_max))
		else $error("lag_search result outside the requested range");

endmodule

// ==== hw/corr_buffer.sv ====
`timescale 1ns/1ps

`include "pitch_macros.svh"

module corr_buffer (
	input logic clock,
	input pitch_pkg::corr_wr_t wr,
	input pitch_pkg::lag_t rd_addr_a,
	output pitch_pkg::word_t rd_data_a,
	input pitch_pkg::lag_t rd_addr_b,
	output pitch_pkg::word_t rd_data_b
);

	// One correlation value per integer lag
	pitch_pkg::word_t mem [2**`CORR_AW];

	//////////////////////////////
	// Write port
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.data;
		end
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////

	// Port A for the lag search
	always_ff @(posedge clock) begin
		rd_data_a <= mem[rd_addr_a];
	end

	// Port B for the interpolator
	always_ff @(posedge clock) begin
		rd_data_b <= mem[rd_addr_b];
	end

endmodule

// ==== hw/pitch_pkg.sv ====
`include "pitch_macros.svh"

package pitch_pkg;

	typedef logic signed [`WORD_W-1:0] word_t;
	typedef logic signed [`ACC_W-1:0] acc_t;
	typedef logic [`CORR_AW-1:0] lag_t;

	// -2 to +2 in steps of 1/3 sample
	typedef logic signed [2:0] frac_t;

	typedef struct packed {
		logic en;
		lag_t addr;
		word_t data;
	} corr_wr_t;

	typedef struct packed {
		lag_t t_min;
		lag_t t_max;
	} search_req_t;

	typedef struct packed {
		lag_t lag;
		word_t corr;
	} search_res_t;

	typedef struct packed {
		lag_t lag;
		frac_t frac;
	} interp_req_t;

	typedef struct packed {
		lag_t lag;
		frac_t frac;
	} pitch_res_t;

	typedef enum logic [2:0] {
		ctrl_idle,
		ctrl_search,
		ctrl_check,
		ctrl_interp,
		ctrl_adjust,
		ctrl_finish
	} ctrl_state_e;

	typedef enum logic [1:0] {
		interp_idle,
		interp_mac,
		interp_round
	} interp_state_e;

	// Q15 interpolation filter for the correlation, 1/3 resolution
	localparam word_t inter_3 [`INTER_LEN] = '{
		16'sd29443, 16'sd25207, 16'sd14701, 16'sd3143,
		-16'sd4402, -16'sd5850, -16'sd2783, 16'sd1211,
		16'sd3130, 16'sd2259, 16'sd0, -16'sd1652,
		-16'sd1666
	};

endpackage

// ==== include/pitch_macros.svh ====
`ifndef PITCH_MACROS_SVH
`define PITCH_MACROS_SVH

//////////////////////////////
// Lag range of the pitch search
//////////////////////////////

`define PIT_MIN 20
`define PIT_MAX 143

// Lag limit in the first subframe
`define EARLY_LAG 84

//////////////////////////////
// Interpolation filter
//////////////////////////////

// Taps on each side of the point
`define L_INTER4 4
`define UP_SAMP 3
`define INTER_LEN 13

// Widths
`define CORR_AW 8
`define WORD_W 16
`define ACC_W 32

`endif
